//--- Makefile
# Verilator build and run of the RSA core testbench

TOP := tb_rsa_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary -j 0 --timescale 1ns/1ps --top-module $(TOP) -f all.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

//--- all.f
+incdir+hw
hw/rsa_pkg.sv
hw/rsa_prep.sv
hw/mont_mult.sv
hw/rsa_core.sv
tb/tb_clock_gen.sv
tb/tb_rsa_core.sv

//--- hw/mont_mult.sv
`timescale 1ns/1ps
`include "rsa_params.svh"

module mont_mult
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	input  rsa_word_t i_n,
	input  rsa_word_t i_a,
	input  rsa_word_t i_b,
	output rsa_word_t o_m,
	output logic      o_fin
);

	localparam int CW = $clog2(`RSA_MONT_STEPS + 1);
	localparam logic [CW-1:0] LAST_STEP = CW'(`RSA_MONT_STEPS);
	// two guard bits hold the partial sum, which stays below 4n
	localparam int AW = `RSA_WIDTH + 2;

	step_state_t   state_r, state_w;
	logic [CW-1:0] cnt_r, cnt_w;
	logic          fin_r, fin_w;
	rsa_word_t     a_r, a_w;
	logic [AW-1:0] acc_r, acc_w;
	logic [AW-1:0] n_ext;
	logic [AW-1:0] sum_b;
	logic [AW-1:0] sum_n;

	assign n_ext = {2'b00, i_n};
	assign sum_b = a_r[0] ? acc_r + {2'b00, i_b} : acc_r;
	// adding n makes the sum even so the halving drops no information
	assign sum_n = sum_b[0] ? sum_b + n_ext : sum_b;

	assign o_m   = acc_r[`RSA_WIDTH-1:0];
	assign o_fin = fin_r;

	always_comb begin
		state_w = state_r;
		cnt_w   = cnt_r;
		fin_w   = 1'b0;
		a_w     = a_r;
		acc_w   = acc_r;

		case (state_r)
			STEP_IDLE: begin
				cnt_w = '0;
				if (i_start) begin
					a_w     = i_a;
					acc_w   = '0;
					state_w = STEP_RUN;
				end
			end
			STEP_RUN: begin
				cnt_w = cnt_r + 1'b1;
				a_w   = a_r >> 1;
				if (cnt_r == LAST_STEP) begin
					// the accumulator is below 2n here so one subtract fully reduces it
					if (acc_r >= n_ext) begin
						acc_w = acc_r - n_ext;
					end
					fin_w   = 1'b1;
					state_w = STEP_IDLE;
				end else begin
					acc_w = sum_n >> 1;
				end
			end
			default: begin
				state_w = STEP_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r <= STEP_IDLE;
			cnt_r   <= '0;
			fin_r   <= 1'b0;
		end else begin
			state_r <= state_w;
			cnt_r   <= cnt_w;
			fin_r   <= fin_w;
		end
	end

	always_ff @(posedge i_clk) begin
		a_r   <= a_w;
		acc_r <= acc_w;
	end

endmodule

//--- hw/rsa_core.sv
`timescale 1ns/1ps
`include "rsa_params.svh"

module rsa_core
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	input  rsa_word_t i_msg,
	input  rsa_word_t i_key,
	input  rsa_word_t i_n,
	output rsa_word_t o_ans,
	output logic      o_finished
);

	localparam int BIT_CW = $clog2(`RSA_WIDTH);
	localparam logic [BIT_CW-1:0] LAST_BIT = BIT_CW'(`RSA_WIDTH - 1);

	core_state_t       state_r, state_w;
	logic [BIT_CW-1:0] bit_cnt_r, bit_cnt_w;
	logic              fin_r, fin_w;
	rsa_word_t         msg_r, msg_w;
	rsa_word_t         key_r, key_w;
	rsa_word_t         n_r, n_w;
	rsa_word_t         ans_r, ans_w;
	rsa_word_t         pow_r, pow_w;
	logic              prep_start_r, prep_start_w;
	logic              mul_start_r, mul_start_w;
	logic              sqr_start_r, sqr_start_w;

	logic              prep_fin;
	logic              mul_fin;
	logic              sqr_fin;
	rsa_word_t         prep_m;
	rsa_word_t         mul_m;
	rsa_word_t         sqr_m;

	assign o_ans      = ans_r;
	assign o_finished = fin_r;

	//////////////////////////////////////////////////////////////////////
	// arithmetic units

	rsa_prep u_prep (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (prep_start_r),
		.i_n     (n_r),
		.i_b     (msg_r),
		.o_m     (prep_m),
		.o_fin   (prep_fin)
	);

	// folds the running power into the answer
	mont_mult u_mont_mul (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (mul_start_r),
		.i_n     (n_r),
		.i_a     (pow_r),
		.i_b     (ans_r),
		.o_m     (mul_m),
		.o_fin   (mul_fin)
	);

	// squares the running power for the next key bit
	mont_mult u_mont_sqr (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (sqr_start_r),
		.i_n     (n_r),
		.i_a     (pow_r),
		.i_b     (pow_r),
		.o_m     (sqr_m),
		.o_fin   (sqr_fin)
	);

	//////////////////////////////////////////////////////////////////////
	// controller

	always_comb begin
		state_w      = state_r;
		bit_cnt_w    = bit_cnt_r;
		fin_w        = 1'b0;
		msg_w        = msg_r;
		key_w        = key_r;
		n_w          = n_r;
		ans_w        = ans_r;
		pow_w        = pow_r;
		prep_start_w = 1'b0;
		mul_start_w  = 1'b0;
		sqr_start_w  = 1'b0;

		case (state_r)
			CORE_IDLE: begin
				if (i_start) begin
					msg_w        = i_msg;
					key_w        = i_key;
					n_w          = i_n;
					ans_w        = rsa_word_t'(1);
					bit_cnt_w    = '0;
					prep_start_w = 1'b1;
					state_w      = CORE_PREP;
				end
			end
			CORE_PREP: begin
				if (prep_fin) begin
					pow_w       = prep_m;
					mul_start_w = 1'b1;
					sqr_start_w = 1'b1;
					state_w     = CORE_STEP;
				end
			end
			CORE_STEP: begin
				// both units were started together and finish together
				if (sqr_fin && mul_fin) begin
					pow_w = sqr_m;
					if (key_r[0]) begin
						ans_w = mul_m;
					end
					state_w = CORE_SHIFT;
				end
			end
			CORE_SHIFT: begin
				key_w     = key_r >> 1;
				bit_cnt_w = bit_cnt_r + 1'b1;
				if (bit_cnt_r == LAST_BIT) begin
					fin_w   = 1'b1;
					state_w = CORE_IDLE;
				end else begin
					mul_start_w = 1'b1;
					sqr_start_w = 1'b1;
					state_w     = CORE_STEP;
				end
			end
			default: begin
				state_w = CORE_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r      <= CORE_IDLE;
			bit_cnt_r    <= '0;
			fin_r        <= 1'b0;
			ans_r        <= rsa_word_t'(1);
			prep_start_r <= 1'b0;
			mul_start_r  <= 1'b0;
			sqr_start_r  <= 1'b0;
		end else begin
			state_r      <= state_w;
			bit_cnt_r    <= bit_cnt_w;
			fin_r        <= fin_w;
			ans_r        <= ans_w;
			prep_start_r <= prep_start_w;
			mul_start_r  <= mul_start_w;
			sqr_start_r  <= sqr_start_w;
		end
	end

	// latched operands and the running power
	always_ff @(posedge i_clk) begin
		msg_r <= msg_w;
		key_r <= key_w;
		n_r   <= n_w;
		pow_r <= pow_w;
	end

endmodule

//--- hw/rsa_params.svh
`ifndef RSA_PARAMS_SVH
`define RSA_PARAMS_SVH

// width of every operand and result word
`define RSA_WIDTH      256

// modular doublings that move the message into the Montgomery domain
`define RSA_PREP_STEPS 256

// add-and-halve steps of one Montgomery product before its final subtract
`define RSA_MONT_STEPS 256

`endif

//--- hw/rsa_pkg.sv
package rsa_pkg;

`include "rsa_params.svh"

	typedef logic [`RSA_WIDTH-1:0] rsa_word_t;

	// top level sequencing of one decryption
	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_PREP,
		CORE_STEP,
		CORE_SHIFT
	} core_state_t;

	// shared by the iterative arithmetic units
	typedef enum logic {
		STEP_IDLE,
		STEP_RUN
	} step_state_t;

endpackage

//--- hw/rsa_prep.sv
`timescale 1ns/1ps
`include "rsa_params.svh"

module rsa_prep
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	input  rsa_word_t i_n,
	input  rsa_word_t i_b,
	output rsa_word_t o_m,
	output logic      o_fin
);

	localparam int CW = $clog2(`RSA_PREP_STEPS);
	localparam logic [CW-1:0] LAST_STEP = CW'(`RSA_PREP_STEPS - 1);

	step_state_t         state_r, state_w;
	logic [CW-1:0]       cnt_r, cnt_w;
	logic                fin_r, fin_w;
	rsa_word_t           m_r, m_w;
	logic [`RSA_WIDTH:0] dbl;
	logic [`RSA_WIDTH:0] n_ext;

	// value stays below n, so one subtract brings the doubled value back in range
	assign dbl   = {m_r, 1'b0};
	assign n_ext = {1'b0, i_n};

	assign o_m   = m_r;
	assign o_fin = fin_r;

	always_comb begin
		state_w = state_r;
		cnt_w   = cnt_r;
		fin_w   = 1'b0;
		m_w     = m_r;

		case (state_r)
			STEP_IDLE: begin
				cnt_w = '0;
				if (i_start) begin
					m_w     = i_b;
					state_w = STEP_RUN;
				end
			end
			STEP_RUN: begin
				cnt_w = cnt_r + 1'b1;
				if (dbl >= n_ext) begin
					m_w = rsa_word_t'(dbl - n_ext);
				end else begin
					m_w = dbl[`RSA_WIDTH-1:0];
				end
				if (cnt_r == LAST_STEP) begin
					fin_w   = 1'b1;
					state_w = STEP_IDLE;
				end
			end
			default: begin
				state_w = STEP_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r <= STEP_IDLE;
			cnt_r   <= '0;
			fin_r   <= 1'b0;
		end else begin
			state_r <= state_w;
			cnt_r   <= cnt_w;
			fin_r   <= fin_w;
		end
	end

	always_ff @(posedge i_clk) begin
		m_r <= m_w;
	end

endmodule

//--- tb/rsa_testdata.txt
// columns: n key msg expected, all in hex
// expected is msg to the power key, modulo n
bb 3 5 7d
bb 10 7 67
21 7 1f 4
ca1 ac1 ae6 41
ca1 11 41 ae6
ca1 0 ae6 1
ca1 1 ae6 ae6
ca1 ac1 0 0
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 0 0123456789abcdeffedcba98765432100123456789abcdeffedcba9876543210 1
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 1 0123456789abcdeffedcba98765432100123456789abcdeffedcba9876543210 0123456789abcdeffedcba98765432100123456789abcdeffedcba9876543210
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0 0
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 2 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff42 1
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 3 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff42 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff42
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff42 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff42
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 1 1
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 2 100000000000000000000000000000000 bd
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 3 100000000000000000000000000000000 bd00000000000000000000000000000000
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 3 10000000000000000 1000000000000000000000000000000000000000000000000
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 100 2 1
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 101 2 2
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff ff 2 8000000000000000000000000000000000000000000000000000000000000000
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0 2 1

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst
);

	int edges = 0;

	initial o_clk = 1'b0;

	// 4 ns period
	always #2 o_clk = ~o_clk;

	// reset is released in the NBA region of the third rising edge
	always @(posedge o_clk) begin
		if (edges < 3) begin
			edges <= edges + 1;
		end
	end

	assign o_rst = (edges < 3);

endmodule

//--- tb/tb_rsa_core.sv
`timescale 1ns/1ps
`include "rsa_params.svh"

module tb_rsa_core
	import rsa_pkg::*;
();

	localparam int W              = `RSA_WIDTH;
	localparam int TIMEOUT_CYCLES = 100000;
	localparam int RANDOM_CASES   = 8;
	localparam int HOLD_CYCLES    = 20;

	// operands of the busy restart case and of the start pulses that must be ignored
	localparam rsa_word_t BUSY_N     = rsa_word_t'(32'hca1);
	localparam rsa_word_t BUSY_KEY   = rsa_word_t'(32'hac1);
	localparam rsa_word_t BUSY_MSG   = rsa_word_t'(32'hae6);
	localparam rsa_word_t IGNORE_N   = rsa_word_t'(32'hbb);
	localparam rsa_word_t IGNORE_KEY = rsa_word_t'(32'h3);
	localparam rsa_word_t IGNORE_MSG = rsa_word_t'(32'h5);

	logic      clk;
	logic      rst;
	logic      start;
	rsa_word_t msg;
	rsa_word_t key;
	rsa_word_t modn;
	rsa_word_t ans;
	logic      finished;

	integer    seed;
	int        ans_errors;
	int        flag_errors;
	int        wait_errors;
	int        file_errors;
	int        vectors_read;

	tb_clock_gen u_clock (
		.o_clk (clk),
		.o_rst (rst)
	);

	rsa_core DUT (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_start    (start),
		.i_msg      (msg),
		.i_key      (key),
		.i_n        (modn),
		.o_ans      (ans),
		.o_finished (finished)
	);

	//////////////////////////////////////////////////////////////////////
	// checks and reference model

	task automatic check_answer(input rsa_word_t got, input rsa_word_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s, got %h, expected %h", $time, what, got, exp);
			ans_errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s, got %b, expected %b", $time, what, got, exp);
			flag_errors++;
		end
	endtask

	// plain square-and-multiply in which every product fits in twice the word width
	function automatic rsa_word_t ref_modexp(input rsa_word_t base, input rsa_word_t e,
		input rsa_word_t n_val);
		logic [2*W-1:0] r;
		logic [2*W-1:0] b;
		logic [2*W-1:0] m;
		m = {{W{1'b0}}, n_val};
		r = {{(2*W-1){1'b0}}, 1'b1} % m;
		b = {{W{1'b0}}, base} % m;
		for (int i = 0; i < W; i++) begin
			if (e[i]) begin
				r = (r * b) % m;
			end
			b = (b * b) % m;
		end
		return r[W-1:0];
	endfunction

	function automatic rsa_word_t random_word();
		rsa_word_t w;
		w = '0;
		for (int i = 0; i < W / 32; i++) begin
			w[i*32 +: 32] = $random(seed);
		end
		return w;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus

	task automatic drive_start(input rsa_word_t n_val, input rsa_word_t key_val,
		input rsa_word_t msg_val);
		@(posedge clk);
		start <= 1'b1;
		modn  <= n_val;
		key   <= key_val;
		msg   <= msg_val;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_finished(output bit seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			if (finished === 1'b1) begin
				seen = 1'b1;
			end else begin
				cycles++;
			end
		end
		if (!seen) begin
			$display("o_finished never arrived within %0d cycles", TIMEOUT_CYCLES);
			wait_errors++;
		end
	endtask

	task automatic run_case(input rsa_word_t n_val, input rsa_word_t key_val,
		input rsa_word_t msg_val, input rsa_word_t exp, input string what);
		bit seen;
		drive_start(n_val, key_val, msg_val);
		wait_finished(seen);
		if (seen) begin
			check_answer(ans, exp, what);
			@(negedge clk);
			check_flag(finished, 1'b0, {what, ", o_finished wider than one cycle"});
		end
	endtask

	task automatic check_reset();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (rst !== 1'b0 && cycles < 100) begin
			@(negedge clk);
			check_flag(finished, 1'b0, "o_finished during reset");
			cycles++;
		end
		if (rst !== 1'b0) begin
			$display("reset was never released");
			wait_errors++;
		end
		repeat (3) begin
			@(negedge clk);
			check_flag(finished, 1'b0, "o_finished after reset");
		end
		check_answer(ans, rsa_word_t'(1), "o_ans after reset");
	endtask

	task automatic run_file_vectors();
		int        fd;
		int        code;
		int        c;
		int        lines;
		rsa_word_t n_val;
		rsa_word_t key_val;
		rsa_word_t msg_val;
		rsa_word_t exp;
		fd = $fopen("tb/rsa_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/rsa_testdata.txt");
			file_errors++;
		end else begin
			lines = 0;
			while (!$feof(fd) && lines < 1000) begin
				lines++;
				code = $fscanf(fd, " %h %h %h %h", n_val, key_val, msg_val, exp);
				if (code == 4) begin
					vectors_read++;
					run_case(n_val, key_val, msg_val, exp,
						$sformatf("vector %0d", vectors_read));
				end else if (code != -1) begin
					// a comment line is skipped up to its newline
					c = $fgetc(fd);
					while (c != 10 && c != -1) begin
						c = $fgetc(fd);
					end
				end
			end
			$fclose(fd);
			if (vectors_read == 0) begin
				$display("no vectors were read from tb/rsa_testdata.txt");
				file_errors++;
			end
		end
	endtask

	task automatic run_random_cases();
		rsa_word_t n_val;
		rsa_word_t key_val;
		rsa_word_t msg_val;
		for (int i = 0; i < RANDOM_CASES; i++) begin
			// moduli shrink from case to case and stay odd and at least 3
			n_val       = random_word() >> (i * 28);
			n_val[1:0]  = 2'b11;
			key_val     = random_word();
			msg_val     = random_word() % n_val;
			run_case(n_val, key_val, msg_val, ref_modexp(msg_val, key_val, n_val),
				$sformatf("random case %0d", i));
		end
	endtask

	task automatic run_busy_restart();
		rsa_word_t exp;
		bit        seen;
		exp = ref_modexp(BUSY_MSG, BUSY_KEY, BUSY_N);
		drive_start(BUSY_N, BUSY_KEY, BUSY_MSG);
		// one pulse during prep and one while the Montgomery units run
		repeat (5) @(posedge clk);
		drive_start(IGNORE_N, IGNORE_KEY, IGNORE_MSG);
		repeat (300) @(posedge clk);
		drive_start(IGNORE_N, IGNORE_KEY, IGNORE_MSG);
		wait_finished(seen);
		if (seen) begin
			check_answer(ans, exp, "busy restart, answer at o_finished");
			for (int i = 0; i < HOLD_CYCLES; i++) begin
				@(negedge clk);
				check_flag(finished, 1'b0, "busy restart, extra o_finished");
				check_answer(ans, exp, "busy restart, o_ans not held");
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		seed         = 57707;
		ans_errors   = 0;
		flag_errors  = 0;
		wait_errors  = 0;
		file_errors  = 0;
		vectors_read = 0;
		start <= 1'b0;
		msg   <= '0;
		key   <= '0;
		modn  <= '0;

		check_reset();
		run_file_vectors();
		run_random_cases();
		run_busy_restart();

		$display("errors: answer %0d, flag %0d, wait %0d, file %0d (vectors %0d)",
			ans_errors, flag_errors, wait_errors, file_errors, vectors_read);
		if (ans_errors + flag_errors + wait_errors + file_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
